//--- files.f
+incdir+verilog
verilog/host_chan_pkg.sv
verilog/host_chan_fifo.sv
verilog/host_chan_rd_path.sv
verilog/host_chan_wr_path.sv
verilog/host_chan_bridge.sv
test/host_chan_bridge_chk.sv
test/host_chan_bridge_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module host_chan_bridge_tb -f files.f -o sim_host_chan
./obj_dir/sim_host_chan > sim.log 2>&1 || true
cat sim.log
if grep -q "^Done: no errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- test/host_chan_bridge_tb.sv
`timescale 1ns/100ps
`include "host_chan_defines.svh"

module host_chan_bridge_tb;

    import host_chan_pkg::*;

    localparam NUM_RD = 100;
    localparam NUM_WR = 100;
    // Worst case of 20 cycles per request
    localparam TIMEOUT_CYCLES = (NUM_RD + NUM_WR) * 20;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic c0_valid = 1'b0;
    logic [`HC_ADDR_WIDTH-1:0] c0_addr = '0;
    t_cl_len c0_cl_len = '0;
    t_mdata c0_mdata = '0;
    logic c0_almost_full;
    logic c1_valid = 1'b0;
    t_req_type c1_type = req_wrline;
    logic [`HC_ADDR_WIDTH-1:0] c1_addr = '0;
    t_cl_len c1_cl_len = '0;
    logic c1_sop = 1'b0;
    logic [`HC_DATA_WIDTH-1:0] c1_data = '0;
    t_mdata c1_mdata = '0;
    logic c1_almost_full;
    logic rsp0_valid;
    logic [`HC_DATA_WIDTH-1:0] rsp0_data;
    t_cl_num rsp0_cl_num;
    t_mdata rsp0_mdata;
    logic rsp1_valid;
    t_rsp_type rsp1_type;
    t_mdata rsp1_mdata;
    logic rd_read;
    logic [`HC_ADDR_WIDTH-1:0] rd_address;
    logic [`HC_BURST_WIDTH-1:0] rd_burstcount;
    logic rd_waitrequest = 1'b0;
    logic [`HC_DATA_WIDTH-1:0] rd_readdata = '0;
    logic rd_readdatavalid = 1'b0;
    logic wr_write;
    logic [`HC_ADDR_WIDTH-1:0] wr_address;
    logic [`HC_BURST_WIDTH-1:0] wr_burstcount;
    logic [`HC_DATA_WIDTH-1:0] wr_writedata;
    logic wr_function;
    logic wr_waitrequest = 1'b0;
    logic wr_writeresponsevalid = 1'b0;

    logic [31:0] lfsr = 32'h5c13_865d;
    int cycle = 0;
    // Avalon memory model state, beats and responses are kept with their due cycle
    logic [`HC_DATA_WIDTH-1:0] rd_beat_q [$];
    int rd_due_q [$];
    int wr_due_q [$];
    int rd_next = 0;
    int rd_start;
    int wr_beats = 0;
    // Set once both request buffers have been driven up to almost-full
    logic buffers_filled = 1'b0;

    host_chan_bridge dut (.*);

    bind host_chan_bridge host_chan_bridge_chk chk (.*);

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // Galois LFSR, one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Commands are judged at the falling edge, where they are stable for the next rising edge
    always @(negedge clk)
    begin
        if (!reset && rd_read && !rd_waitrequest)
        begin
            rd_start = cycle + 2 + int'(rand_bits(2));
            if (rd_start < rd_next)
                rd_start = rd_next;
            for (int b = 0; b < int'(rd_burstcount); b++)
            begin
                rd_beat_q.push_back(`HC_DATA_WIDTH'(rd_address) + `HC_DATA_WIDTH'(b));
                rd_due_q.push_back(rd_start + b);
            end
            rd_next = rd_start + int'(rd_burstcount);
        end
        if (!reset && wr_write && !wr_waitrequest)
        begin
            if (wr_function)
            begin
                wr_due_q.push_back(cycle + 1 + int'(rand_bits(2)));
            end
            else
            begin
                wr_beats++;
                // One response once the last beat of the burst is in
                if (wr_beats == int'(wr_burstcount))
                begin
                    wr_beats = 0;
                    wr_due_q.push_back(cycle + 1 + int'(rand_bits(2)));
                end
            end
        end
    end

    // Both Avalon sides stall at the start until the request buffers reach almost-full
    always @(posedge clk)
    begin
        #1;
        if (c0_almost_full && c1_almost_full)
        begin
            buffers_filled = 1'b1;
        end
        rd_waitrequest = (rand_bits(2) == 0) || !buffers_filled;
        wr_waitrequest = (rand_bits(2) == 0) || !buffers_filled;
        rd_readdatavalid = 1'b0;
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle)
        begin
            rd_readdatavalid = 1'b1;
            rd_readdata = rd_beat_q.pop_front();
            void'(rd_due_q.pop_front());
        end
        wr_writeresponsevalid = 1'b0;
        if (wr_due_q.size() > 0 && wr_due_q[0] <= cycle)
        begin
            wr_writeresponsevalid = 1'b1;
            void'(wr_due_q.pop_front());
        end
    end

    task automatic send_reads();
        int i;
        for (i = 0; i < NUM_RD; i++)
        begin
            repeat (int'(rand_bits(2)))
            begin
                @(posedge clk);
                #1 c0_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            while (c0_almost_full)
            begin
                c0_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            c0_valid = 1'b1;
            c0_addr = rand_bits(20);
            c0_cl_len = t_cl_len'(rand_bits(2));
            c0_mdata = t_mdata'(i);
        end
        @(posedge clk);
        #1 c0_valid = 1'b0;
    endtask

    task automatic send_writes();
        int i;
        int l;
        for (i = 0; i < NUM_WR; i++)
        begin
            repeat (int'(rand_bits(2)))
            begin
                @(posedge clk);
                #1 c1_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            while (c1_almost_full)
            begin
                c1_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            c1_valid = 1'b1;
            c1_mdata = t_mdata'(16'h8000 + i);
            c1_data = {rand_bits(32), rand_bits(32)};
            if (rand_bits(2) == 0)
            begin
                c1_type = req_wrfence;
                c1_sop = 1'b0;
                c1_cl_len = '0;
            end
            else
            begin
                // Burst lines follow back to back, only the first is checked against almost-full
                c1_type = req_wrline;
                c1_sop = 1'b1;
                c1_cl_len = t_cl_len'(rand_bits(2));
                c1_addr = rand_bits(20);
                for (l = 1; l <= int'(c1_cl_len); l++)
                begin
                    @(posedge clk);
                    #1;
                    c1_sop = 1'b0;
                    c1_data = {rand_bits(32), rand_bits(32)};
                end
            end
        end
        @(posedge clk);
        #1 c1_valid = 1'b0;
    endtask

    always @(negedge clk)
    begin
        if (dut.chk.err_count != 0)
        begin
            $display("Done: errors found");
            $fatal(1, "A checker assertion failed");
        end
        else if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Done: errors found");
            $fatal(1, "Timeout with responses still outstanding after %0d cycles", cycle);
        end
    end

    initial
    begin
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        fork
            send_reads();
            send_writes();
        join
        repeat (2) @(posedge clk);
        // Every queued tag has to come back before the run can end
        while (dut.chk.rd_outstanding != 0 || dut.chk.wr_outstanding != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (dut.chk.err_count != 0)
        begin
            $display("Done: errors found");
            $fatal(1, "A checker assertion failed");
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- test/host_chan_bridge_chk.sv
`timescale 1ns/100ps
`include "host_chan_defines.svh"

module host_chan_bridge_chk
(
    input logic clk,
    input logic reset,
    input logic c0_valid,
    input logic [`HC_ADDR_WIDTH-1:0] c0_addr,
    input host_chan_pkg::t_cl_len c0_cl_len,
    input host_chan_pkg::t_mdata c0_mdata,
    input logic c0_almost_full,
    input logic c1_valid,
    input host_chan_pkg::t_req_type c1_type,
    input logic [`HC_ADDR_WIDTH-1:0] c1_addr,
    input host_chan_pkg::t_cl_len c1_cl_len,
    input logic c1_sop,
    input logic [`HC_DATA_WIDTH-1:0] c1_data,
    input host_chan_pkg::t_mdata c1_mdata,
    input logic c1_almost_full,
    input logic rsp0_valid,
    input logic [`HC_DATA_WIDTH-1:0] rsp0_data,
    input host_chan_pkg::t_cl_num rsp0_cl_num,
    input host_chan_pkg::t_mdata rsp0_mdata,
    input logic rsp1_valid,
    input host_chan_pkg::t_rsp_type rsp1_type,
    input host_chan_pkg::t_mdata rsp1_mdata,
    input logic rd_read,
    input logic [`HC_ADDR_WIDTH-1:0] rd_address,
    input logic [`HC_BURST_WIDTH-1:0] rd_burstcount,
    input logic rd_waitrequest,
    input logic rd_readdatavalid,
    input logic wr_write,
    input logic [`HC_ADDR_WIDTH-1:0] wr_address,
    input logic [`HC_BURST_WIDTH-1:0] wr_burstcount,
    input logic [`HC_DATA_WIDTH-1:0] wr_writedata,
    input logic wr_function,
    input logic wr_waitrequest,
    input logic wr_writeresponsevalid
);

    import host_chan_pkg::*;

    // Read requests in arrival order, walked by both the issue and the response pointers
    logic [`HC_ADDR_WIDTH-1:0] rq_addr [1024];
    t_cl_len rq_len [1024];
    t_mdata rq_mdata [1024];
    logic [9:0] rq_tail;
    logic [9:0] rd_cmd_head;
    logic [9:0] rd_rsp_head;
    t_cl_num rd_line;

    // Expected Avalon write beats, one per accelerator line
    logic [`HC_ADDR_WIDTH-1:0] wb_addr [1024];
    logic [`HC_BURST_WIDTH-1:0] wb_count [1024];
    logic [`HC_DATA_WIDTH-1:0] wb_data [1024];
    logic wb_fn [1024];
    logic [9:0] wb_tail;
    logic [9:0] wb_head;
    logic [`HC_ADDR_WIDTH-1:0] cur_addr;
    t_cl_len cur_len;

    // Expected write responses, one per burst or fence
    logic wq_fence [1024];
    t_mdata wq_mdata [1024];
    logic [9:0] wq_tail;
    logic [9:0] wq_head;

    int err_count = 0;
    logic [9:0] rd_outstanding;
    logic [9:0] wr_outstanding;
    logic [9:0] rd_buffered;
    logic [9:0] wr_buffered;

    // Buffer occupancy is what was sent minus what Avalon accepted
    assign rd_outstanding = rq_tail - rd_rsp_head;
    assign wr_outstanding = wq_tail - wq_head;
    assign rd_buffered = rq_tail - rd_cmd_head;
    assign wr_buffered = wb_tail - wb_head;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rq_tail <= '0;
            rd_cmd_head <= '0;
            rd_rsp_head <= '0;
            rd_line <= '0;
            wb_tail <= '0;
            wb_head <= '0;
            wq_tail <= '0;
            wq_head <= '0;
        end
        else
        begin
            if (c0_valid)
            begin
                rq_addr[rq_tail] <= c0_addr;
                rq_len[rq_tail] <= c0_cl_len;
                rq_mdata[rq_tail] <= c0_mdata;
                rq_tail <= rq_tail + 1'b1;
            end
            if (rd_read && !rd_waitrequest)
                rd_cmd_head <= rd_cmd_head + 1'b1;
            // The last line of a burst moves on to the next request
            if (rsp0_valid)
            begin
                if (rd_line == t_cl_num'(rq_len[rd_rsp_head]))
                begin
                    rd_line <= '0;
                    rd_rsp_head <= rd_rsp_head + 1'b1;
                end
                else
                begin
                    rd_line <= rd_line + 1'b1;
                end
            end
            if (c1_valid)
            begin
                // Fences go out at address zero, other lines use the sop address
                wb_addr[wb_tail] <= (c1_type == req_wrfence) ? '0 :
                    (c1_sop ? c1_addr : cur_addr);
                // A fence is one beat, every burst line carries the sop length
                wb_count[wb_tail] <= (c1_type == req_wrfence) ? `HC_BURST_WIDTH'(1) :
                    `HC_BURST_WIDTH'(c1_sop ? c1_cl_len : cur_len) + `HC_BURST_WIDTH'(1);
                wb_data[wb_tail] <= c1_data;
                wb_fn[wb_tail] <= (c1_type == req_wrfence);
                wb_tail <= wb_tail + 1'b1;
                if (c1_sop)
                begin
                    cur_addr <= c1_addr;
                    cur_len <= c1_cl_len;
                end
                if (c1_sop || c1_type == req_wrfence)
                begin
                    wq_fence[wq_tail] <= (c1_type == req_wrfence);
                    wq_mdata[wq_tail] <= c1_mdata;
                    wq_tail <= wq_tail + 1'b1;
                end
            end
            if (wr_write && !wr_waitrequest)
                wb_head <= wb_head + 1'b1;
            if (rsp1_valid)
                wq_head <= wq_head + 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) reset |=> !rd_read && !wr_write &&
        !rsp0_valid && !rsp1_valid && !c0_almost_full && !c1_almost_full)
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: outputs active after reset", $time);
        end

    a_rd_cmd: assert property (@(posedge clk) disable iff (reset) rd_read |->
        rd_buffered != 0 && rd_address == rq_addr[rd_cmd_head] &&
        rd_burstcount == `HC_BURST_WIDTH'(rq_len[rd_cmd_head]) + `HC_BURST_WIDTH'(1))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: wrong read command", $time);
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (reset) rd_read && rd_waitrequest |=>
        rd_read && $stable(rd_address) && $stable(rd_burstcount))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: read command moved", $time);
        end

    a_rd_rsp: assert property (@(posedge clk) disable iff (reset) rsp0_valid |->
        rd_outstanding != 0 && rsp0_mdata == rq_mdata[rd_rsp_head] && rsp0_cl_num == rd_line &&
        rsp0_data == `HC_DATA_WIDTH'(rq_addr[rd_rsp_head]) + `HC_DATA_WIDTH'(rd_line))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: wrong read response", $time);
        end

    a_rd_lat: assert property (@(posedge clk) disable iff (reset)
        rsp0_valid == $past(rd_readdatavalid))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: read response latency", $time);
        end

    a_wr_beat: assert property (@(posedge clk) disable iff (reset) wr_write |->
        wr_buffered != 0 && wr_address == wb_addr[wb_head] &&
        wr_burstcount == wb_count[wb_head] &&
        wr_writedata == wb_data[wb_head] && wr_function == wb_fn[wb_head])
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: wrong write beat", $time);
        end

    a_wr_hold: assert property (@(posedge clk) disable iff (reset) wr_write && wr_waitrequest |=>
        wr_write && $stable(wr_address) && $stable(wr_burstcount) &&
        $stable(wr_writedata) && $stable(wr_function))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: write beat moved", $time);
        end

    a_wr_rsp: assert property (@(posedge clk) disable iff (reset) rsp1_valid |->
        wr_outstanding != 0 && rsp1_mdata == wq_mdata[wq_head] &&
        rsp1_type == (wq_fence[wq_head] ? rsp_wrfence : rsp_wrline))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: wrong write response", $time);
        end

    a_wr_lat: assert property (@(posedge clk) disable iff (reset)
        rsp1_valid == $past(wr_writeresponsevalid))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: write response latency", $time);
        end

    // Almost-full tracks occupancy exactly and the slack is never exceeded
    a_almost_full: assert property (@(posedge clk) disable iff (reset)
        c0_almost_full == (rd_buffered >= 10'(`HC_ALMOST_FULL_THRESHOLD)) &&
        c1_almost_full == (wr_buffered >= 10'(`HC_ALMOST_FULL_THRESHOLD)) &&
        rd_buffered <= 10'(`HC_BUF_ENTRIES) && wr_buffered <= 10'(`HC_BUF_ENTRIES))
        else
        begin
            err_count++;
            $error("CHECK FAILED at %0t: almost-full mismatch", $time);
        end

endmodule

//--- verilog/host_chan_bridge.sv
`timescale 1ns/100ps
`include "host_chan_defines.svh"

module host_chan_bridge
(
    input  logic clk,
    input  logic reset,

    // Accelerator read requests
    input  logic c0_valid,
    input  logic [`HC_ADDR_WIDTH-1:0] c0_addr,
    input  host_chan_pkg::t_cl_len c0_cl_len,
    input  host_chan_pkg::t_mdata c0_mdata,
    output logic c0_almost_full,

    // Accelerator write requests
    input  logic c1_valid,
    input  host_chan_pkg::t_req_type c1_type,
    input  logic [`HC_ADDR_WIDTH-1:0] c1_addr,
    input  host_chan_pkg::t_cl_len c1_cl_len,
    input  logic c1_sop,
    input  logic [`HC_DATA_WIDTH-1:0] c1_data,
    input  host_chan_pkg::t_mdata c1_mdata,
    output logic c1_almost_full,

    // Responses to the accelerator
    output logic rsp0_valid,
    output logic [`HC_DATA_WIDTH-1:0] rsp0_data,
    output host_chan_pkg::t_cl_num rsp0_cl_num,
    output host_chan_pkg::t_mdata rsp0_mdata,
    output logic rsp1_valid,
    output host_chan_pkg::t_rsp_type rsp1_type,
    output host_chan_pkg::t_mdata rsp1_mdata,

    // Avalon read side
    output logic rd_read,
    output logic [`HC_ADDR_WIDTH-1:0] rd_address,
    output logic [`HC_BURST_WIDTH-1:0] rd_burstcount,
    input  logic rd_waitrequest,
    input  logic [`HC_DATA_WIDTH-1:0] rd_readdata,
    input  logic rd_readdatavalid,

    // Avalon write side
    output logic wr_write,
    output logic [`HC_ADDR_WIDTH-1:0] wr_address,
    output logic [`HC_BURST_WIDTH-1:0] wr_burstcount,
    output logic [`HC_DATA_WIDTH-1:0] wr_writedata,
    output logic wr_function,
    input  logic wr_waitrequest,
    input  logic wr_writeresponsevalid
);

    // Reads and writes run in fully independent pipelines
    host_chan_rd_path rd_path
    (
        .clk,
        .reset,
        .c0_valid,
        .c0_addr,
        .c0_cl_len,
        .c0_mdata,
        .c0_almost_full,
        .rd_read,
        .rd_address,
        .rd_burstcount,
        .rd_waitrequest,
        .rd_readdata,
        .rd_readdatavalid,
        .rsp0_valid,
        .rsp0_data,
        .rsp0_cl_num,
        .rsp0_mdata
    );

    host_chan_wr_path wr_path
    (
        .clk,
        .reset,
        .c1_valid,
        .c1_type,
        .c1_addr,
        .c1_cl_len,
        .c1_sop,
        .c1_data,
        .c1_mdata,
        .c1_almost_full,
        .wr_write,
        .wr_address,
        .wr_burstcount,
        .wr_writedata,
        .wr_function,
        .wr_waitrequest,
        .wr_writeresponsevalid,
        .rsp1_valid,
        .rsp1_type,
        .rsp1_mdata
    );

endmodule

//--- verilog/host_chan_wr_path.sv
`timescale 1ns/100ps
`include "host_chan_defines.svh"

module host_chan_wr_path
(
    input  logic clk,
    input  logic reset,

    // Accelerator write requests, one line per cycle
    input  logic c1_valid,
    input  host_chan_pkg::t_req_type c1_type,
    input  logic [`HC_ADDR_WIDTH-1:0] c1_addr,
    input  host_chan_pkg::t_cl_len c1_cl_len,
    input  logic c1_sop,
    input  logic [`HC_DATA_WIDTH-1:0] c1_data,
    input  host_chan_pkg::t_mdata c1_mdata,
    output logic c1_almost_full,

    // Avalon write command and response
    output logic wr_write,
    output logic [`HC_ADDR_WIDTH-1:0] wr_address,
    output logic [`HC_BURST_WIDTH-1:0] wr_burstcount,
    output logic [`HC_DATA_WIDTH-1:0] wr_writedata,
    output logic wr_function,
    input  logic wr_waitrequest,
    input  logic wr_writeresponsevalid,

    // Write responses to the accelerator
    output logic rsp1_valid,
    output host_chan_pkg::t_rsp_type rsp1_type,
    output host_chan_pkg::t_mdata rsp1_mdata
);

    import host_chan_pkg::*;

    localparam BURST_W = `HC_BURST_WIDTH;

    logic buf_fence;
    logic [`HC_ADDR_WIDTH-1:0] buf_addr;
    t_cl_len buf_cl_len;
    logic buf_sop;
    logic [`HC_DATA_WIDTH-1:0] buf_data;
    t_mdata buf_mdata;
    logic buf_not_empty;
    logic buf_deq;

    logic [`HC_ADDR_WIDTH-1:0] burst_addr;
    t_cl_len burst_len;

    logic trk_enq;
    logic trk_not_full;
    logic trk_fence;
    t_mdata trk_mdata;

    // The fence test is done on entry so the buffer carries a single flag
    host_chan_fifo
    #(
        .N_DATA_BITS(1 + `HC_ADDR_WIDTH + $bits(t_cl_len) + 1 + `HC_DATA_WIDTH +
                     $bits(t_mdata)),
        .N_ENTRIES(`HC_BUF_ENTRIES),
        .THRESHOLD(`HC_ALMOST_FULL_THRESHOLD),
        .REGISTER_OUTPUT(1)
    )
    req_buf
    (
        .clk,
        .reset,
        .enq_data({c1_type == req_wrfence, c1_addr, c1_cl_len, c1_sop, c1_data, c1_mdata}),
        .enq_en(c1_valid),
        .not_full(),
        .almost_full(c1_almost_full),
        .first({buf_fence, buf_addr, buf_cl_len, buf_sop, buf_data, buf_mdata}),
        .deq_en(buf_deq),
        .not_empty(buf_not_empty)
    );

    // Every line waits for tracker room, which keeps the command steady under waitrequest
    assign wr_write = buf_not_empty && trk_not_full;
    assign buf_deq = wr_write && !wr_waitrequest;

    // Address and length of the sop line cover the rest of the burst
    always_ff @(posedge clk)
    begin
        if (buf_deq && buf_sop)
        begin
            burst_addr <= buf_addr;
            burst_len <= buf_cl_len;
        end
    end

    always_comb
    begin
        wr_writedata = buf_data;
        wr_function = 1'b0;
        if (buf_fence)
        begin
            // Fence is a single beat flagged on the function bit
            wr_address = '0;
            wr_burstcount = BURST_W'(1);
            wr_function = 1'b1;
        end
        else if (buf_sop)
        begin
            wr_address = buf_addr;
            wr_burstcount = BURST_W'(buf_cl_len) + BURST_W'(1);
        end
        else
        begin
            wr_address = burst_addr;
            wr_burstcount = BURST_W'(burst_len) + BURST_W'(1);
        end
    end

    // Track whole bursts and fences, never the individual lines
    assign trk_enq = buf_deq && (buf_sop || buf_fence);

    host_chan_fifo
    #(
        .N_DATA_BITS(1 + $bits(t_mdata)),
        .N_ENTRIES(`HC_TRACKER_DEPTH),
        .THRESHOLD(`HC_TRACKER_DEPTH),
        .REGISTER_OUTPUT(0)
    )
    wr_tracker
    (
        .clk,
        .reset,
        .enq_data({buf_fence, buf_mdata}),
        .enq_en(trk_enq),
        .not_full(trk_not_full),
        .almost_full(),
        .first({trk_fence, trk_mdata}),
        .deq_en(wr_writeresponsevalid),
        .not_empty()
    );

    // Avalon answers each burst once, in order, so each response retires the head
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp1_valid <= 1'b0;
        end
        else
        begin
            rsp1_valid <= wr_writeresponsevalid;
        end
    end

    always_ff @(posedge clk)
    begin
        rsp1_type <= trk_fence ? rsp_wrfence : rsp_wrline;
        rsp1_mdata <= trk_mdata;
    end

endmodule

//--- verilog/host_chan_rd_path.sv
`timescale 1ns/100ps
`include "host_chan_defines.svh"

module host_chan_rd_path
(
    input  logic clk,
    input  logic reset,

    // Accelerator read requests
    input  logic c0_valid,
    input  logic [`HC_ADDR_WIDTH-1:0] c0_addr,
    input  host_chan_pkg::t_cl_len c0_cl_len,
    input  host_chan_pkg::t_mdata c0_mdata,
    output logic c0_almost_full,

    // Avalon read command and data
    output logic rd_read,
    output logic [`HC_ADDR_WIDTH-1:0] rd_address,
    output logic [`HC_BURST_WIDTH-1:0] rd_burstcount,
    input  logic rd_waitrequest,
    input  logic [`HC_DATA_WIDTH-1:0] rd_readdata,
    input  logic rd_readdatavalid,

    // Read responses to the accelerator
    output logic rsp0_valid,
    output logic [`HC_DATA_WIDTH-1:0] rsp0_data,
    output host_chan_pkg::t_cl_num rsp0_cl_num,
    output host_chan_pkg::t_mdata rsp0_mdata
);

    import host_chan_pkg::*;

    localparam BURST_W = `HC_BURST_WIDTH;

    logic [`HC_ADDR_WIDTH-1:0] buf_addr;
    t_cl_len buf_cl_len;
    t_mdata buf_mdata;
    logic buf_not_empty;
    logic buf_deq;

    logic trk_not_full;
    logic trk_deq;
    t_cl_len trk_cl_len;
    t_mdata trk_mdata;

    t_cl_num cl_num;

    // Request buffer absorbs the requests that arrive after almost-full rises
    host_chan_fifo
    #(
        .N_DATA_BITS(`HC_ADDR_WIDTH + $bits(t_cl_len) + $bits(t_mdata)),
        .N_ENTRIES(`HC_BUF_ENTRIES),
        .THRESHOLD(`HC_ALMOST_FULL_THRESHOLD),
        .REGISTER_OUTPUT(1)
    )
    req_buf
    (
        .clk,
        .reset,
        .enq_data({c0_addr, c0_cl_len, c0_mdata}),
        .enq_en(c0_valid),
        .not_full(),
        .almost_full(c0_almost_full),
        .first({buf_addr, buf_cl_len, buf_mdata}),
        .deq_en(buf_deq),
        .not_empty(buf_not_empty)
    );

    // Issue only when the tracker can record the burst
    // The buffer head only moves on acceptance, so the command holds under waitrequest
    assign rd_read = buf_not_empty && trk_not_full;
    assign buf_deq = rd_read && !rd_waitrequest;
    assign rd_address = buf_addr;
    assign rd_burstcount = BURST_W'(buf_cl_len) + BURST_W'(1);

    // Tracker keeps the burst length and tag of every accepted read
    host_chan_fifo
    #(
        .N_DATA_BITS($bits(t_cl_len) + $bits(t_mdata)),
        .N_ENTRIES(`HC_TRACKER_DEPTH),
        .THRESHOLD(`HC_TRACKER_DEPTH),
        .REGISTER_OUTPUT(0)
    )
    rd_tracker
    (
        .clk,
        .reset,
        .enq_data({buf_cl_len, buf_mdata}),
        .enq_en(buf_deq),
        .not_full(trk_not_full),
        .almost_full(),
        .first({trk_cl_len, trk_mdata}),
        .deq_en(trk_deq),
        .not_empty()
    );

    // The last line of the oldest burst retires its tracker entry
    assign trk_deq = rd_readdatavalid && (cl_num == t_cl_num'(trk_cl_len));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp0_valid <= 1'b0;
            cl_num <= '0;
        end
        else
        begin
            rsp0_valid <= rd_readdatavalid;
            if (trk_deq)
            begin
                cl_num <= '0;
            end
            else if (rd_readdatavalid)
            begin
                cl_num <= cl_num + 1'b1;
            end
        end
    end

    // Response payload is qualified by rsp0_valid
    always_ff @(posedge clk)
    begin
        rsp0_data <= rd_readdata;
        rsp0_cl_num <= cl_num;
        rsp0_mdata <= trk_mdata;
    end

endmodule

//--- verilog/host_chan_fifo.sv
`timescale 1ns/100ps

module host_chan_fifo
#(
    parameter N_DATA_BITS = 32,
    parameter N_ENTRIES = 8,
    parameter THRESHOLD = 4,
    parameter REGISTER_OUTPUT = 0
)
(
    input  logic clk,
    input  logic reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,
    output logic almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    localparam PTR_BITS = $clog2(N_ENTRIES);
    // Wide enough for a full memory plus the output register
    localparam CNT_BITS = $clog2(N_ENTRIES + 2);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] occupancy;
    logic mem_enq;
    logic mem_deq;

    // Writes beyond capacity are dropped, so the caller must honor not_full
    assign not_full = (count < CNT_BITS'(N_ENTRIES));
    assign mem_enq = enq_en && not_full;
    assign almost_full = (occupancy >= CNT_BITS'(THRESHOLD));

    // Storage array needs no reset since count qualifies every entry
    always_ff @(posedge clk)
    begin
        if (mem_enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap explicitly because the depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (mem_enq)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (mem_deq)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(mem_enq) - CNT_BITS'(mem_deq);
        end
    end

    generate
        if (REGISTER_OUTPUT != 0)
        begin : g_reg_out
            logic out_valid;
            logic [N_DATA_BITS-1:0] out_data;

            // Refill the output stage whenever it is empty or being consumed
            assign mem_deq = (count != '0) && (!out_valid || deq_en);
            assign first = out_data;
            assign not_empty = out_valid;
            // The staged head entry still counts toward occupancy
            assign occupancy = count + CNT_BITS'(out_valid);

            always_ff @(posedge clk)
            begin
                if (mem_deq)
                begin
                    out_data <= mem[rd_ptr];
                end
            end

            always_ff @(posedge clk)
            begin
                if (reset)
                begin
                    out_valid <= 1'b0;
                end
                else if (mem_deq)
                begin
                    out_valid <= 1'b1;
                end
                else if (deq_en)
                begin
                    out_valid <= 1'b0;
                end
            end
        end
        else
        begin : g_comb_out
            // Head entry is read straight from the array
            assign mem_deq = deq_en && (count != '0);
            assign first = mem[rd_ptr];
            assign not_empty = (count != '0);
            assign occupancy = count;
        end
    endgenerate

endmodule

//--- verilog/host_chan_pkg.sv
package host_chan_pkg;

    // Request kinds on the accelerator request channels
    typedef enum logic [1:0]
    {
        req_rdline  = 2'd0,
        req_wrline  = 2'd1,
        req_wrfence = 2'd2
    } t_req_type;

    // Response kinds returned to the accelerator
    typedef enum logic [1:0]
    {
        rsp_rdline  = 2'd0,
        rsp_wrline  = 2'd1,
        rsp_wrfence = 2'd2
    } t_rsp_type;

    // Burst length minus one, so 0 is a single line and 3 is four lines
    typedef logic [1:0] t_cl_len;

    // Index of a line within its burst
    typedef logic [1:0] t_cl_num;

    // Accelerator tag, returned untouched with the response
    typedef logic [15:0] t_mdata;

endpackage

//--- verilog/host_chan_defines.svh
`ifndef HOST_CHAN_DEFINES_SVH
`define HOST_CHAN_DEFINES_SVH

// Line address width on both the accelerator and Avalon sides
`define HC_ADDR_WIDTH 32

// Reduced line width to keep the model small
`define HC_DATA_WIDTH 64

// Avalon burst count width, wide enough for a four-line burst
`define HC_BURST_WIDTH 3

// Buffer occupancy at which almost-full is raised
`define HC_ALMOST_FULL_THRESHOLD 8

// Four entries of slack above the threshold absorb requests still in flight
`define HC_BUF_ENTRIES (`HC_ALMOST_FULL_THRESHOLD + 4)

// Bursts in flight per direction
`define HC_TRACKER_DEPTH 8

`endif
